// ==== Makefile ====
SIM      = verilator
TOP      = calcTb
FILELIST = src.f
FLAGS    = --timing --assert
BUILD    = obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP)

clean:
	rm -rf $(BUILD)

// ==== common/calcOpPkg.sv ====
package calcOpPkg;

  import regFilePkg::*;

  ////////////////////////////////////////////////////////////////////
  // Instruction set
  ////////////////////////////////////////////////////////////////////

  // Codes 2 to 4 are reserved
  typedef enum logic [2:0] {
    opWrite = 3'd0,
    opRead = 3'd1,
    opLess = 3'd5,
    opXor = 3'd6,
    opShift = 3'd7
  } opCode;

  // Second operand field, an address or a shift count
  typedef union packed {
    regAddr srcB;
    logic [addrWidth-1:0] shiftAmt;
  } srcField;

  ////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [10:0] pad;
    opCode op;
    regAddr srcA;
    srcField src;
    regAddr dest;
    regData data;
  } calcCmd;

  localparam int cmdWidth = $bits(calcCmd);

endpackage

// ==== common/regFilePkg.sv ====
package regFilePkg;

  ////////////////////////////////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////////////////////////////////

  localparam int dataWidth = 16;
  localparam int addrWidth = 5;
  localparam int regCount = 32;

  // Operand switches
  localparam int nibbleWidth = 4;

  typedef logic [dataWidth-1:0] regData;
  typedef logic [addrWidth-1:0] regAddr;

endpackage

// ==== entry/commandEntry.sv ====
`timescale 1ns/100ps

module commandEntry
  import regFilePkg::*;
  import calcOpPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic step,
  input  logic opSel,
  input  logic abort,
  input  logic [nibbleWidth-1:0] nibble,
  output logic cmdValid,
  input  logic cmdReady,
  output calcCmd cmd
);

  opCode curOp;
  logic [2:0] fieldCnt;
  logic xfer;
  logic stepTaken;
  logic lastField;
  calcCmd cmdReg;

  // Number of knob steps for each instruction
  function automatic logic [2:0] fieldTotal(input opCode op);
    case (op)
      opWrite, opLess, opXor: fieldTotal = 3'd6;
      opShift: fieldTotal = 3'd5;
      default: fieldTotal = 3'd2;
    endcase
  endfunction

  // Reserved codes fall back to read
  function automatic opCode loadOp(input logic [2:0] code);
    case (code)
      3'd0, 3'd1, 3'd5, 3'd6, 3'd7: loadOp = opCode'(code);
      default: loadOp = opRead;
    endcase
  endfunction

  assign xfer = cmdValid & cmdReady;
  assign stepTaken = step & ~cmdValid & ~abort & ~opSel;
  assign lastField = (fieldCnt == fieldTotal(curOp) - 3'd1);
  assign cmd = cmdReg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      curOp <= opWrite;
      fieldCnt <= '0;
      cmdValid <= 1'b0;
    end else begin
      if (opSel && !abort) begin
        curOp <= loadOp(nibble[2:0]);
      end
      if (abort || opSel || xfer) begin
        fieldCnt <= '0;
      end else if (stepTaken) begin
        fieldCnt <= fieldCnt + 3'd1;
      end
      if (abort || xfer) begin
        cmdValid <= 1'b0;
      end else if (stepTaken && lastField) begin
        cmdValid <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand fields, one nibble per step
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (stepTaken) begin
      if (fieldCnt == '0) begin
        cmdReg <= '0;
      end
      cmdReg.op <= curOp;
      case (curOp)
        opWrite: begin
          case (fieldCnt)
            3'd0: cmdReg.dest[3:0] <= nibble;
            3'd1: cmdReg.dest[addrWidth-1] <= nibble[0];
            3'd2: cmdReg.data[3:0] <= nibble;
            3'd3: cmdReg.data[7:4] <= nibble;
            3'd4: cmdReg.data[11:8] <= nibble;
            3'd5: cmdReg.data[15:12] <= nibble;
            default: ;
          endcase
        end
        opLess, opXor: begin
          case (fieldCnt)
            3'd0: cmdReg.srcA[3:0] <= nibble;
            3'd1: cmdReg.srcA[addrWidth-1] <= nibble[0];
            3'd2: cmdReg.src.srcB[3:0] <= nibble;
            3'd3: cmdReg.src.srcB[addrWidth-1] <= nibble[0];
            3'd4: cmdReg.dest[3:0] <= nibble;
            3'd5: cmdReg.dest[addrWidth-1] <= nibble[0];
            default: ;
          endcase
        end
        opShift: begin
          case (fieldCnt)
            3'd0: cmdReg.srcA[3:0] <= nibble;
            3'd1: cmdReg.srcA[addrWidth-1] <= nibble[0];
            3'd2: cmdReg.dest[3:0] <= nibble;
            3'd3: cmdReg.dest[addrWidth-1] <= nibble[0];
            3'd4: cmdReg.src.shiftAmt <= addrWidth'(nibble);
            default: ;
          endcase
        end
        default: begin
          case (fieldCnt)
            3'd0: cmdReg.srcA[3:0] <= nibble;
            3'd1: cmdReg.srcA[addrWidth-1] <= nibble[0];
            default: ;
          endcase
        end
      endcase
    end
  end

endmodule

// ==== execute/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit
  import regFilePkg::*;
  import calcOpPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic clearRegs,
  input  logic cmdValid,
  output logic cmdReady,
  input  calcCmd cmd,
  output logic resultValid,
  input  logic resultReady,
  output regAddr resultAddr,
  output regData resultData
);

  regData regFile [regCount];
  logic readPhase;
  logic execPhase;
  calcCmd cmdHeld;
  regData opA;
  regData opB;
  regData aluOut;
  logic regWrite;

  // One command in flight at a time
  assign cmdReady = ~(readPhase | execPhase | resultValid);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readPhase <= 1'b0;
      execPhase <= 1'b0;
      resultValid <= 1'b0;
    end else begin
      readPhase <= cmdValid & cmdReady;
      execPhase <= readPhase;
      if (execPhase) begin
        resultValid <= 1'b1;
      end else if (resultReady) begin
        resultValid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand fetch and result capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (cmdValid && cmdReady) begin
      cmdHeld <= cmd;
    end
    if (readPhase) begin
      opA <= regFile[cmdHeld.srcA];
      opB <= regFile[cmdHeld.src.srcB];
    end
    if (execPhase) begin
      resultAddr <= (cmdHeld.op == opRead) ? cmdHeld.srcA : cmdHeld.dest;
      resultData <= aluOut;
    end
  end

  always_comb begin
    regWrite = 1'b1;
    case (cmdHeld.op)
      opWrite: aluOut = cmdHeld.data;
      opLess: aluOut = ($signed(opA) < $signed(opB)) ? regData'(1) : '0;
      opXor: aluOut = opA ^ opB;
      // Same field, read as a count
      opShift: aluOut = opA << cmdHeld.src.shiftAmt;
      default: begin
        aluOut = opA;
        regWrite = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else if (clearRegs) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else if (execPhase && regWrite) begin
      regFile[cmdHeld.dest] <= aluOut;
    end
  end

endmodule

// ==== source/calcTop.sv ====
`timescale 1ns/100ps

module calcTop
  import regFilePkg::*;
  import calcOpPkg::*;
#(
  parameter int queueDepth = 4
) (
  input  logic clk,
  input  logic rstN,
  input  logic rotA,
  input  logic rotB,
  input  logic [nibbleWidth-1:0] nibble,
  input  logic opSel,
  input  logic abort,
  input  logic clearRegs,
  output logic resultValid,
  input  logic resultReady,
  output regAddr resultAddr,
  output regData resultData
);

  logic step;
  logic cmdValid;
  logic cmdReady;
  calcCmd cmd;
  logic qValid;
  logic qReady;
  calcCmd qCmd;

  rotaryStep i_rotaryStep (
    .clk(clk),
    .rstN(rstN),
    .rotA(rotA),
    .rotB(rotB),
    .step(step)
  );

  commandEntry i_commandEntry (
    .clk(clk),
    .rstN(rstN),
    .step(step),
    .opSel(opSel),
    .abort(abort),
    .nibble(nibble),
    .cmdValid(cmdValid),
    .cmdReady(cmdReady),
    .cmd(cmd)
  );

  commandQueue #(
    .queueDepth(queueDepth)
  ) i_commandQueue (
    .clk(clk),
    .rstN(rstN),
    .inValid(cmdValid),
    .inReady(cmdReady),
    .inCmd(cmd),
    .outValid(qValid),
    .outReady(qReady),
    .outCmd(qCmd)
  );

  executeUnit i_executeUnit (
    .clk(clk),
    .rstN(rstN),
    .clearRegs(clearRegs),
    .cmdValid(qValid),
    .cmdReady(qReady),
    .cmd(qCmd),
    .resultValid(resultValid),
    .resultReady(resultReady),
    .resultAddr(resultAddr),
    .resultData(resultData)
  );

endmodule

// ==== source/commandQueue.sv ====
`timescale 1ns/100ps

module commandQueue
  import calcOpPkg::*;
#(
  parameter int queueDepth = 4
) (
  input  logic clk,
  input  logic rstN,
  input  logic inValid,
  output logic inReady,
  input  calcCmd inCmd,
  output logic outValid,
  input  logic outReady,
  output calcCmd outCmd
);

  localparam int ptrWidth = $clog2(queueDepth);

  calcCmd mem [queueDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;
  logic wrEn;
  logic rdEn;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(queueDepth - 1)) begin
      nextPtr = '0;
    end else begin
      nextPtr = ptr + 1'b1;
    end
  endfunction

  assign inReady = (count != (ptrWidth + 1)'(queueDepth));
  assign outValid = (count != '0);
  assign outCmd = mem[rdPtr];
  assign wrEn = inValid & inReady;
  assign rdEn = outValid & outReady;

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= inCmd;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (rdEn) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (wrEn && !rdEn) begin
        count <= count + 1'b1;
      end else if (rdEn && !wrEn) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== source/rotaryStep.sv ====
`timescale 1ns/100ps

module rotaryStep (
  input  logic clk,
  input  logic rstN,
  input  logic rotA,
  input  logic rotB,
  output logic step
);

  logic contactLevel;
  logic levelDly;

  // Both contacts must agree before the level moves
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      contactLevel <= 1'b0;
      levelDly <= 1'b0;
      step <= 1'b0;
    end else begin
      if (rotA && rotB) begin
        contactLevel <= 1'b1;
      end else if (!rotA && !rotB) begin
        contactLevel <= 1'b0;
      end
      levelDly <= contactLevel;
      step <= contactLevel & ~levelDly;
    end
  end

endmodule

// ==== src.f ====
common/regFilePkg.sv
common/calcOpPkg.sv
source/rotaryStep.sv
entry/commandEntry.sv
source/commandQueue.sv
execute/executeUnit.sv
source/calcTop.sv
test/calcTb.sv

// ==== test/calcTb.sv ====
`timescale 1ns/100ps

module calcTb
  import regFilePkg::*;
  import calcOpPkg::*;
;

  localparam int numCmds = 35;
  localparam int timeoutCycles = numCmds * 400 + 500;

  logic clk;
  logic rstN;
  logic rotA;
  logic rotB;
  logic [nibbleWidth-1:0] nibble;
  logic opSel;
  logic abort;
  logic clearRegs;
  logic resultValid;
  logic resultReady;
  regAddr resultAddr;
  regData resultData;

  // Reference model state
  regData refMem [regCount];
  logic [addrWidth+dataWidth-1:0] expQ [$];
  regAddr headAddr;
  regData headData;
  int expCount;
  int seed;

  calcTop #(
    .queueDepth(4)
  ) i_calcTop (
    .clk(clk),
    .rstN(rstN),
    .rotA(rotA),
    .rotB(rotB),
    .nibble(nibble),
    .opSel(opSel),
    .abort(abort),
    .clearRegs(clearRegs),
    .resultValid(resultValid),
    .resultReady(resultReady),
    .resultAddr(resultAddr),
    .resultData(resultData)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  function void refreshHead();
    expCount = expQ.size();
    if (expCount > 0) begin
      {headAddr, headData} = expQ[0];
    end else begin
      headAddr = '0;
      headData = '0;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Result checks
  //////////////////////////////////////////////////////////////////////

  // Nothing may come out without a command behind it
  resultExpected: assert property (@(posedge clk) disable iff (!rstN)
    resultValid |-> expCount > 0)
    else stopRun($sformatf("ERROR %0t: result with no command pending", $time));

  resultMatches: assert property (@(posedge clk) disable iff (!rstN)
    (resultValid && resultReady) |-> (resultAddr == headAddr && resultData == headData))
    else stopRun($sformatf("ERROR %0t: result %0d=%h, expected %0d=%h", $time,
      $sampled(resultAddr), $sampled(resultData), $sampled(headAddr),
      $sampled(headData)));

  always @(posedge clk) begin
    if (rstN && resultValid && resultReady && expQ.size() > 0) begin
      void'(expQ.pop_front());
      refreshHead();
    end
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    stopRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // One detent with contacts closed then open
  task automatic turnKnob(input logic [3:0] value);
    nibble = value;
    rotA = 1'b1;
    rotB = 1'b1;
    waitCycles(3);
    rotA = 1'b0;
    rotB = 1'b0;
    waitCycles(3);
  endtask

  task automatic selectOp(input opCode op);
    nibble = {1'b0, op};
    opSel = 1'b1;
    waitCycles(1);
    opSel = 1'b0;
  endtask

  task automatic expectCmd(input opCode op, input regAddr a, input regAddr b,
                           input regAddr d, input regData imm);
    regAddr addr;
    regData val;
    addr = d;
    case (op)
      opWrite: val = imm;
      opRead: begin
        addr = a;
        val = refMem[a];
      end
      opLess: val = ($signed(refMem[a]) < $signed(refMem[b])) ? 16'd1 : 16'd0;
      opXor: val = refMem[a] ^ refMem[b];
      default: val = refMem[a] << b[3:0];
    endcase
    if (op != opRead) begin
      refMem[d] = val;
    end
    expQ.push_back({addr, val});
    refreshHead();
  endtask

  task automatic feedFields(input opCode op, input regAddr a, input regAddr b,
                            input regAddr d, input regData imm);
    case (op)
      opWrite: begin
        turnKnob(d[3:0]);
        turnKnob({3'b0, d[4]});
        turnKnob(imm[3:0]);
        turnKnob(imm[7:4]);
        turnKnob(imm[11:8]);
        turnKnob(imm[15:12]);
      end
      opRead: begin
        turnKnob(a[3:0]);
        turnKnob({3'b0, a[4]});
      end
      opShift: begin
        turnKnob(a[3:0]);
        turnKnob({3'b0, a[4]});
        turnKnob(d[3:0]);
        turnKnob({3'b0, d[4]});
        turnKnob(b[3:0]);
      end
      default: begin
        turnKnob(a[3:0]);
        turnKnob({3'b0, a[4]});
        turnKnob(b[3:0]);
        turnKnob({3'b0, b[4]});
        turnKnob(d[3:0]);
        turnKnob({3'b0, d[4]});
      end
    endcase
  endtask

  task automatic runCmd(input opCode op, input regAddr a, input regAddr b,
                        input regAddr d, input regData imm);
    selectOp(op);
    expectCmd(op, a, b, d, imm);
    feedFields(op, a, b, d, imm);
  endtask

  task automatic waitDrain();
    while (expCount != 0) begin
      @(posedge clk);
    end
    waitCycles(2);
  endtask

  initial begin
    logic [31:0] r;
    regAddr wAddr [6];
    seed = 16930;
    rstN = 1'b0;
    rotA = 1'b0;
    rotB = 1'b0;
    nibble = '0;
    opSel = 1'b0;
    abort = 1'b0;
    clearRegs = 1'b0;
    resultReady = 1'b1;
    for (int i = 0; i < regCount; i++) begin
      refMem[i] = '0;
    end
    refreshHead();
    waitCycles(2);
    rstN = 1'b1;
    waitCycles(3);
    assert (resultValid === 1'b0)
      else stopRun($sformatf("ERROR %0t: resultValid high after reset", $time));

    // Writes then reads of written and untouched registers
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      wAddr[i] = {1'b0, r[3:0]};
      runCmd(opWrite, 5'd0, 5'd0, wAddr[i], r[31:16]);
    end
    for (int i = 0; i < 6; i++) begin
      runCmd(opRead, wAddr[i], 5'd0, 5'd0, 16'd0);
    end
    runCmd(opRead, 5'd20, 5'd0, 5'd0, 16'd0);
    runCmd(opRead, 5'd27, 5'd0, 5'd0, 16'd0);
    runCmd(opRead, 5'd31, 5'd0, 5'd0, 16'd0);
    waitDrain();

    // Signed compare with one negative operand
    r = $random(seed);
    runCmd(opWrite, 5'd0, 5'd0, 5'd16, r[15:0] | 16'h8000);
    runCmd(opWrite, 5'd0, 5'd0, 5'd17, r[31:16] & 16'h7fff);
    runCmd(opLess, 5'd16, 5'd17, 5'd21, 16'd0);
    runCmd(opLess, 5'd17, 5'd16, 5'd22, 16'd0);
    runCmd(opXor, wAddr[2], 5'd16, 5'd23, 16'd0);
    runCmd(opXor, wAddr[3], wAddr[4], 5'd24, 16'd0);
    waitDrain();

    r = $random(seed);
    runCmd(opShift, wAddr[0], 5'd0, 5'd25, 16'd0);
    runCmd(opShift, 5'd16, {1'b0, r[3:0]}, 5'd26, 16'd0);
    runCmd(opShift, wAddr[1], 5'd15, 5'd28, 16'd0);
    waitDrain();

    // Stalled output fills the queue and holds the last command in entry
    resultReady = 1'b0;
    r = $random(seed);
    runCmd(opXor, 5'd16, 5'd17, 5'd24, 16'd0);
    runCmd(opWrite, 5'd0, 5'd0, 5'd25, r[15:0]);
    runCmd(opRead, 5'd25, 5'd0, 5'd0, 16'd0);
    runCmd(opShift, 5'd24, 5'd4, 5'd26, 16'd0);
    runCmd(opLess, 5'd26, 5'd24, 5'd29, 16'd0);
    runCmd(opRead, 5'd26, 5'd0, 5'd0, 16'd0);
    waitCycles(20);
    assert (resultValid === 1'b1)
      else stopRun($sformatf("ERROR %0t: no result held while stalled", $time));
    resultReady = 1'b1;
    waitDrain();

    // Partial write dropped by abort
    selectOp(opWrite);
    turnKnob(4'h3);
    turnKnob(4'h1);
    turnKnob(4'h9);
    abort = 1'b1;
    waitCycles(1);
    abort = 1'b0;
    r = $random(seed);
    expectCmd(opWrite, 5'd0, 5'd0, 5'd27, r[15:0]);
    feedFields(opWrite, 5'd0, 5'd0, 5'd27, r[15:0]);
    waitDrain();

    clearRegs = 1'b1;
    waitCycles(1);
    clearRegs = 1'b0;
    for (int i = 0; i < regCount; i++) begin
      refMem[i] = '0;
    end
    runCmd(opRead, wAddr[0], 5'd0, 5'd0, 16'd0);
    runCmd(opRead, 5'd16, 5'd0, 5'd0, 16'd0);
    runCmd(opRead, 5'd27, 5'd0, 5'd0, 16'd0);
    runCmd(opRead, 5'd24, 5'd0, 5'd0, 16'd0);
    waitDrain();

    if (expCount == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stopRun($sformatf("ERROR %0t: %0d results never arrived", $time, expCount));
    end
  end

endmodule
